//--- logic/vecproc_settings.svh
`ifndef VECPROC_SETTINGS_SVH
`define VECPROC_SETTINGS_SVH

// scalar width, also the width of one vector lane.
`define VP_XLEN 16

// vector lanes and full vector width.
`define VP_LANES 8
`define VP_VLEN 128

// register count per file and index width.
`define VP_REGS 32
`define VP_RIDX 5

// memory word address width.
`define VP_AW 12

// first fetch address after reset.
`define VP_RESET_PC 12'h000

`endif

//--- logic/vecproc_pkg.sv
`default_nettype none
`include "vecproc_settings.svh"

package vecproc_pkg;

   // encodings are fixed, the program image depends on them.
   typedef enum logic [4:0] {
      op_nop    = 5'd0,
      op_add    = 5'd1,
      op_sub    = 5'd2,
      op_and    = 5'd3,
      op_or     = 5'd4,
      op_xor    = 5'd5,
      op_shl    = 5'd6,
      op_shr    = 5'd7,
      op_addi   = 5'd8,
      op_lui    = 5'd9,
      op_load   = 5'd10,
      op_store  = 5'd11,
      op_vadd   = 5'd12,
      op_vsub   = 5'd13,
      op_vmul   = 5'd14,
      op_vbcast = 5'd15,
      op_vext   = 5'd16,
      op_halt   = 5'd17
   } opcode_e;

   typedef enum logic [3:0] {
      alu_add,
      alu_sub,
      alu_and,
      alu_or,
      alu_xor,
      alu_shl,
      alu_shr,
      alu_pass_b,
      alu_vadd,
      alu_vsub,
      alu_vmul,
      alu_vbcast,
      alu_vext
   } alu_op_e;

   typedef enum logic [1:0] {
      wb_alu,
      wb_mem,
      wb_lane
   } wb_sel_e;

   // all zero is a bubble.
   typedef struct packed {
      logic    wre;
      logic    vector_wre;
      logic    mem_write;
      logic    mem_read;
      wb_sel_e wb_sel;
      alu_op_e alu_op;
      logic    halt;
   } ctrl_t;

   typedef struct packed {
      opcode_e              opcode;
      logic [`VP_RIDX-1:0]  rd;
      logic [`VP_RIDX-1:0]  rs1;
      logic [`VP_RIDX-1:0]  rs2;
      logic [11:0]          imm;
   } instr_t;

   typedef struct packed {
      ctrl_t                ctrl;
      logic [`VP_RIDX-1:0]  rs1;
      logic [`VP_RIDX-1:0]  rs2;
      logic [`VP_RIDX-1:0]  rd;
      logic [11:0]          imm;
      logic [`VP_XLEN-1:0]  src_a;
      logic [`VP_XLEN-1:0]  src_b;
      logic [`VP_VLEN-1:0]  vsrc_a;
      logic [`VP_VLEN-1:0]  vsrc_b;
   } decoded_t;

   typedef struct packed {
      logic               write;
      logic [`VP_AW-1:0]  addr;
      logic [31:0]        wdata;
   } mem_req_t;

   typedef struct packed {
      logic [31:0] rdata;
   } mem_rsp_t;

   typedef enum logic [1:0] {
      arb_idle,
      arb_fetch_busy,
      arb_data_busy
   } arb_state_e;

endpackage

`default_nettype wire

//--- logic/mem_arbiter.sv
`timescale 1ns/1ns
`default_nettype none
`include "vecproc_settings.svh"

module mem_arbiter (
   input  logic                   clk,
   input  logic                   reset,
   input  logic                   fetch_req_valid,
   input  logic [`VP_AW-1:0]      fetch_addr,
   input  logic                   data_req_valid,
   input  vecproc_pkg::mem_req_t  data_req,
   input  logic                   mem_req_ready,
   input  logic                   mem_rsp_valid,
   input  vecproc_pkg::mem_rsp_t  mem_rsp,
   output logic                   fetch_req_ready,
   output logic                   data_req_ready,
   output logic                   fetch_rsp_valid,
   output logic                   data_rsp_valid,
   output logic [31:0]            rsp_data,
   output logic                   mem_req_valid,
   output vecproc_pkg::mem_req_t  mem_req
);
   import vecproc_pkg::*;

   arb_state_e state;
   logic       hold_fetch;
   logic       pick_fetch;
   logic       idle;

   assign idle = (state == arb_idle);

   // a fetch already shown on the port keeps it until accepted.
   assign pick_fetch = hold_fetch || !data_req_valid;

   assign mem_req_valid = idle && (pick_fetch ? fetch_req_valid : data_req_valid);

   always_comb begin
      mem_req = data_req;
      if (pick_fetch) begin
         mem_req = '0;
         mem_req.addr = fetch_addr;
      end
   end

   assign fetch_req_ready = idle && pick_fetch && mem_req_ready;
   assign data_req_ready  = idle && !pick_fetch && mem_req_ready;

   // responses go back to whoever owns the read.
   assign fetch_rsp_valid = (state == arb_fetch_busy) && mem_rsp_valid;
   assign data_rsp_valid  = (state == arb_data_busy) && mem_rsp_valid;
   assign rsp_data        = mem_rsp.rdata;

   always_ff @(posedge clk) begin
      if (reset) begin
         state      <= arb_idle;
         hold_fetch <= 1'b0;
      end else begin
         case (state)
            arb_idle: begin
               hold_fetch <= mem_req_valid && !mem_req_ready && pick_fetch;
               if (mem_req_valid && mem_req_ready && !mem_req.write) begin
                  state <= pick_fetch ? arb_fetch_busy : arb_data_busy;
               end
            end
            default: begin
               if (mem_rsp_valid) begin
                  state <= arb_idle;
               end
            end
         endcase
      end
   end

   // memory must only answer reads that were forwarded.
   a_no_idle_rsp : assert property (@(posedge clk) disable iff (reset)
      idle |-> !mem_rsp_valid)
      else $error("mem_arbiter: response with no read outstanding");

endmodule

`default_nettype wire

//--- logic/fetch_stage.sv
`timescale 1ns/1ns
`default_nettype none
`include "vecproc_settings.svh"

module fetch_stage (
   input  logic                 clk,
   input  logic                 reset,
   input  logic                 req_ready,
   input  logic                 rsp_valid,
   input  logic [31:0]          rsp_data,
   input  logic                 take,
   input  logic                 stop,
   output logic                 req_valid,
   output logic [`VP_AW-1:0]    addr,
   output vecproc_pkg::instr_t  instr,
   output logic                 instr_valid
);
   import vecproc_pkg::*;

   logic [`VP_AW-1:0] pc;
   logic              pending;
   logic              halt_fetched;
   logic              can_issue;
   instr_t            rsp_word;

   assign rsp_word = rsp_data;
   assign addr     = pc;

   // next fetch only once the held word is gone.
   assign can_issue = !req_valid && !pending && (!instr_valid || take)
                      && !stop && !halt_fetched;

   always_ff @(posedge clk) begin
      if (reset) begin
         pc           <= `VP_RESET_PC;
         req_valid    <= 1'b0;
         pending      <= 1'b0;
         instr_valid  <= 1'b0;
         halt_fetched <= 1'b0;
      end else begin
         if (req_valid && req_ready) begin
            req_valid <= 1'b0;
            pending   <= 1'b1;
         end else if (can_issue) begin
            req_valid <= 1'b1;
         end
         if (rsp_valid) begin
            pending     <= 1'b0;
            instr_valid <= 1'b1;
            pc          <= pc + 1'b1;
            // nothing past a halt gets fetched.
            if (rsp_word.opcode == op_halt) begin
               halt_fetched <= 1'b1;
            end
         end else if (take) begin
            instr_valid <= 1'b0;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (rsp_valid) begin
         instr <= rsp_word;
      end
   end

endmodule

`default_nettype wire

//--- logic/register_file.sv
`timescale 1ns/1ns
`default_nettype none
`include "vecproc_settings.svh"

module register_file (
   input  logic                 clk,
   input  logic                 reset,
   input  logic [`VP_RIDX-1:0]  rs1,
   input  logic [`VP_RIDX-1:0]  rs2,
   input  logic                 wre,
   input  logic                 vector_wre,
   input  logic [`VP_RIDX-1:0]  rd,
   input  logic [`VP_XLEN-1:0]  wdata,
   input  logic [`VP_VLEN-1:0]  vwdata,
   output logic [`VP_XLEN-1:0]  rdata1,
   output logic [`VP_XLEN-1:0]  rdata2,
   output logic [`VP_VLEN-1:0]  vrdata1,
   output logic [`VP_VLEN-1:0]  vrdata2
);
   logic [`VP_XLEN-1:0] regs  [`VP_REGS];
   logic [`VP_VLEN-1:0] vregs [`VP_REGS];

   always_ff @(posedge clk) begin
      if (reset) begin
         for (int i = 0; i < `VP_REGS; i++) begin
            regs[i]  <= '0;
            vregs[i] <= '0;
         end
      end else begin
         if (wre) begin
            regs[rd] <= wdata;
         end
         if (vector_wre) begin
            vregs[rd] <= vwdata;
         end
      end
   end

   // write-through, then scalar r0 forced to zero.
   always_comb begin
      rdata1  = (wre && rd == rs1) ? wdata : regs[rs1];
      rdata2  = (wre && rd == rs2) ? wdata : regs[rs2];
      vrdata1 = (vector_wre && rd == rs1) ? vwdata : vregs[rs1];
      vrdata2 = (vector_wre && rd == rs2) ? vwdata : vregs[rs2];
      if (rs1 == '0) begin
         rdata1 = '0;
      end
      if (rs2 == '0) begin
         rdata2 = '0;
      end
   end

endmodule

`default_nettype wire

//--- logic/decode_stage.sv
`timescale 1ns/1ns
`default_nettype none
`include "vecproc_settings.svh"

module decode_stage (
   input  logic                   clk,
   input  logic                   reset,
   input  vecproc_pkg::instr_t    instr,
   input  logic                   instr_valid,
   input  logic [`VP_XLEN-1:0]    rdata1,
   input  logic [`VP_XLEN-1:0]    rdata2,
   input  logic [`VP_VLEN-1:0]    vrdata1,
   input  logic [`VP_VLEN-1:0]    vrdata2,
   input  logic [`VP_RIDX-1:0]    exe_rd,
   input  vecproc_pkg::ctrl_t     exe_ctrl,
   input  logic                   exe_stall,
   output logic                   take,
   output logic [`VP_RIDX-1:0]    rs1,
   output logic [`VP_RIDX-1:0]    rs2,
   output vecproc_pkg::decoded_t  out,
   output logic                   out_valid
);
   import vecproc_pkg::*;

   ctrl_t               ctrl;
   logic                hazard;
   logic [`VP_XLEN-1:0] src_b;

   assign rs1 = instr.rs1;
   assign rs2 = instr.rs2;

   always_comb begin
      ctrl = '0;
      ctrl.wre = instr.opcode inside {op_add, op_sub, op_and, op_or, op_xor,
                                      op_shl, op_shr, op_addi, op_lui, op_load, op_vext};
      ctrl.vector_wre = instr.opcode inside {op_vadd, op_vsub, op_vmul, op_vbcast};
      ctrl.mem_write  = (instr.opcode == op_store);
      ctrl.mem_read   = (instr.opcode == op_load);
      ctrl.halt       = (instr.opcode == op_halt);
      case (instr.opcode)
         op_load: ctrl.wb_sel = wb_mem;
         op_vext: ctrl.wb_sel = wb_lane;
         default: ctrl.wb_sel = wb_alu;
      endcase
      case (instr.opcode)
         op_sub:    ctrl.alu_op = alu_sub;
         op_and:    ctrl.alu_op = alu_and;
         op_or:     ctrl.alu_op = alu_or;
         op_xor:    ctrl.alu_op = alu_xor;
         op_shl:    ctrl.alu_op = alu_shl;
         op_shr:    ctrl.alu_op = alu_shr;
         op_lui:    ctrl.alu_op = alu_pass_b;
         op_vadd:   ctrl.alu_op = alu_vadd;
         op_vsub:   ctrl.alu_op = alu_vsub;
         op_vmul:   ctrl.alu_op = alu_vmul;
         op_vbcast: ctrl.alu_op = alu_vbcast;
         op_vext:   ctrl.alu_op = alu_vext;
         default:   ctrl.alu_op = alu_add;
      endcase
   end

   // addi sign-extends, lui fills the upper bits.
   always_comb begin
      case (instr.opcode)
         op_addi: src_b = {{4{instr.imm[11]}}, instr.imm};
         op_lui:  src_b = {instr.imm, 4'b0000};
         default: src_b = rdata2;
      endcase
   end

   // no forwarding, so any match against a writer waits one slot.
   assign hazard = instr_valid && (exe_ctrl.wre || exe_ctrl.vector_wre)
                   && (instr.rs1 == exe_rd || instr.rs2 == exe_rd);

   assign out_valid = instr_valid && !hazard;
   assign take      = out_valid && !exe_stall;

   always_comb begin
      out.ctrl   = out_valid ? ctrl : '0;
      out.rs1    = instr.rs1;
      out.rs2    = instr.rs2;
      out.rd     = instr.rd;
      out.imm    = instr.imm;
      out.src_a  = rdata1;
      out.src_b  = src_b;
      out.vsrc_a = vrdata1;
      out.vsrc_b = vrdata2;
   end

   // the inserted bubble clears the producer out of execute.
   a_one_bubble : assert property (@(posedge clk) disable iff (reset)
      hazard && !exe_stall |=> !hazard)
      else $error("decode_stage: hazard outlived its bubble");

endmodule

`default_nettype wire

//--- logic/decode_execute_register.sv
`timescale 1ns/1ns
`default_nettype none
`include "vecproc_settings.svh"

module decode_execute_register (
   input  logic                   clk,
   input  logic                   reset,
   input  vecproc_pkg::decoded_t  in,
   input  logic                   in_valid,
   input  logic                   stall,
   output vecproc_pkg::decoded_t  out
);

   // a cleared control word is a bubble.
   always_ff @(posedge clk) begin
      if (reset) begin
         out.ctrl <= '0;
      end else if (!stall) begin
         out <= in;
         if (!in_valid) begin
            out.ctrl <= '0;
         end
      end
   end

   // decode must hand over a clean control word with a bubble.
   a_bubble_no_write : assert property (@(posedge clk) disable iff (reset)
      !in_valid |-> !(in.ctrl.wre || in.ctrl.vector_wre || in.ctrl.mem_write))
      else $error("decode_execute_register: bubble carries a write enable");

endmodule

`default_nettype wire

//--- logic/execute_stage.sv
`timescale 1ns/1ns
`default_nettype none
`include "vecproc_settings.svh"

module execute_stage (
   input  logic                   clk,
   input  logic                   reset,
   input  vecproc_pkg::decoded_t  in,
   input  logic                   data_req_ready,
   input  logic                   data_rsp_valid,
   input  logic [31:0]            rsp_data,
   output logic                   data_req_valid,
   output vecproc_pkg::mem_req_t  data_req,
   output logic                   stall,
   output logic                   wre,
   output logic                   vector_wre,
   output logic [`VP_RIDX-1:0]    rd,
   output logic [`VP_XLEN-1:0]    wdata,
   output logic [`VP_VLEN-1:0]    vwdata,
   output logic                   halted
);
   import vecproc_pkg::*;

   logic                issued;
   logic                done;
   logic [`VP_XLEN-1:0] addr_sum;
   logic [`VP_XLEN-1:0] alu_result;
   logic [`VP_XLEN-1:0] lane_value;

   assign addr_sum = in.src_a + `VP_XLEN'(in.imm);

   // a load stops requesting once accepted and waits for its data.
   assign data_req_valid = in.ctrl.mem_write || (in.ctrl.mem_read && !issued);
   assign data_req.write = in.ctrl.mem_write;
   assign data_req.addr  = addr_sum[`VP_AW-1:0];
   assign data_req.wdata = 32'(in.src_b);

   assign done  = in.ctrl.mem_write ? data_req_ready : data_rsp_valid;
   assign stall = (in.ctrl.mem_write || in.ctrl.mem_read) && !done;

   always_ff @(posedge clk) begin
      if (reset) begin
         issued <= 1'b0;
         halted <= 1'b0;
      end else begin
         if (in.ctrl.mem_read && data_req_valid && data_req_ready) begin
            issued <= 1'b1;
         end else if (data_rsp_valid) begin
            issued <= 1'b0;
         end
         if (in.ctrl.halt) begin
            halted <= 1'b1;
         end
      end
   end

   always_comb begin
      case (in.ctrl.alu_op)
         alu_sub:    alu_result = in.src_a - in.src_b;
         alu_and:    alu_result = in.src_a & in.src_b;
         alu_or:     alu_result = in.src_a | in.src_b;
         alu_xor:    alu_result = in.src_a ^ in.src_b;
         alu_shl:    alu_result = in.src_a << in.src_b[3:0];
         alu_shr:    alu_result = in.src_a >> in.src_b[3:0];
         alu_pass_b: alu_result = in.src_b;
         default:    alu_result = in.src_a + in.src_b;
      endcase
   end

   // per lane, results wrap at lane width.
   always_comb begin
      for (int i = 0; i < `VP_LANES; i++) begin
         case (in.ctrl.alu_op)
            alu_vsub: vwdata[i*`VP_XLEN +: `VP_XLEN] =
               in.vsrc_a[i*`VP_XLEN +: `VP_XLEN] - in.vsrc_b[i*`VP_XLEN +: `VP_XLEN];
            alu_vmul: vwdata[i*`VP_XLEN +: `VP_XLEN] =
               in.vsrc_a[i*`VP_XLEN +: `VP_XLEN] * in.vsrc_b[i*`VP_XLEN +: `VP_XLEN];
            alu_vbcast: vwdata[i*`VP_XLEN +: `VP_XLEN] = in.src_a;
            default: vwdata[i*`VP_XLEN +: `VP_XLEN] =
               in.vsrc_a[i*`VP_XLEN +: `VP_XLEN] + in.vsrc_b[i*`VP_XLEN +: `VP_XLEN];
         endcase
      end
   end

   assign lane_value = in.vsrc_a[in.imm[2:0]*`VP_XLEN +: `VP_XLEN];

   always_comb begin
      case (in.ctrl.wb_sel)
         wb_mem:  wdata = rsp_data[`VP_XLEN-1:0];
         wb_lane: wdata = lane_value;
         default: wdata = alu_result;
      endcase
   end

   assign rd         = in.rd;
   assign wre        = in.ctrl.wre && !stall;
   assign vector_wre = in.ctrl.vector_wre;

   // pipeline register must hold the access steady under back-pressure.
   a_req_stable : assert property (@(posedge clk) disable iff (reset)
      data_req_valid && !data_req_ready |=> data_req_valid && $stable(data_req))
      else $error("execute_stage: data request changed before acceptance");

endmodule

`default_nettype wire

//--- logic/vecproc_top.sv
`timescale 1ns/1ns
`default_nettype none
`include "vecproc_settings.svh"

module vecproc_top (
   input  logic                   clk,
   input  logic                   reset,
   input  logic                   mem_req_ready,
   input  logic                   mem_rsp_valid,
   input  vecproc_pkg::mem_rsp_t  mem_rsp,
   output logic                   mem_req_valid,
   output vecproc_pkg::mem_req_t  mem_req,
   output logic                   halted
);
   import vecproc_pkg::*;

   logic                fetch_req_valid;
   logic                fetch_req_ready;
   logic                fetch_rsp_valid;
   logic [`VP_AW-1:0]   fetch_addr;
   logic                data_req_valid;
   logic                data_req_ready;
   logic                data_rsp_valid;
   mem_req_t            data_req;
   logic [31:0]         rsp_data;
   instr_t              instr;
   logic                instr_valid;
   logic                take;
   logic [`VP_RIDX-1:0] rs1;
   logic [`VP_RIDX-1:0] rs2;
   logic [`VP_XLEN-1:0] rdata1;
   logic [`VP_XLEN-1:0] rdata2;
   logic [`VP_VLEN-1:0] vrdata1;
   logic [`VP_VLEN-1:0] vrdata2;
   decoded_t            de_out;
   logic                de_valid;
   decoded_t            exe_in;
   logic                exe_stall;
   logic                wre;
   logic                vector_wre;
   logic [`VP_RIDX-1:0] rd;
   logic [`VP_XLEN-1:0] wdata;
   logic [`VP_VLEN-1:0] vwdata;

   mem_arbiter u_arbiter (
      .clk(clk), .reset(reset),
      .fetch_req_valid(fetch_req_valid), .fetch_addr(fetch_addr),
      .data_req_valid(data_req_valid), .data_req(data_req),
      .mem_req_ready(mem_req_ready), .mem_rsp_valid(mem_rsp_valid), .mem_rsp(mem_rsp),
      .fetch_req_ready(fetch_req_ready), .data_req_ready(data_req_ready),
      .fetch_rsp_valid(fetch_rsp_valid), .data_rsp_valid(data_rsp_valid),
      .rsp_data(rsp_data), .mem_req_valid(mem_req_valid), .mem_req(mem_req)
   );

   fetch_stage u_fetch (
      .clk(clk), .reset(reset), .req_ready(fetch_req_ready),
      .rsp_valid(fetch_rsp_valid), .rsp_data(rsp_data), .take(take), .stop(halted),
      .req_valid(fetch_req_valid), .addr(fetch_addr),
      .instr(instr), .instr_valid(instr_valid)
   );

   register_file u_regs (
      .clk(clk), .reset(reset), .rs1(rs1), .rs2(rs2),
      .wre(wre), .vector_wre(vector_wre), .rd(rd), .wdata(wdata), .vwdata(vwdata),
      .rdata1(rdata1), .rdata2(rdata2), .vrdata1(vrdata1), .vrdata2(vrdata2)
   );

   decode_stage u_decode (
      .clk(clk), .reset(reset), .instr(instr), .instr_valid(instr_valid),
      .rdata1(rdata1), .rdata2(rdata2), .vrdata1(vrdata1), .vrdata2(vrdata2),
      .exe_rd(exe_in.rd), .exe_ctrl(exe_in.ctrl), .exe_stall(exe_stall),
      .take(take), .rs1(rs1), .rs2(rs2), .out(de_out), .out_valid(de_valid)
   );

   decode_execute_register u_de_reg (
      .clk(clk), .reset(reset), .in(de_out), .in_valid(de_valid),
      .stall(exe_stall), .out(exe_in)
   );

   execute_stage u_execute (
      .clk(clk), .reset(reset), .in(exe_in),
      .data_req_ready(data_req_ready), .data_rsp_valid(data_rsp_valid),
      .rsp_data(rsp_data), .data_req_valid(data_req_valid), .data_req(data_req),
      .stall(exe_stall), .wre(wre), .vector_wre(vector_wre), .rd(rd),
      .wdata(wdata), .vwdata(vwdata), .halted(halted)
   );

endmodule

`default_nettype wire

//--- test/vecproc_checker.sv
`timescale 1ns/1ns
`default_nettype none
`include "vecproc_settings.svh"

module vecproc_checker #(
   parameter int max_stores = 64
) (
   input  logic                   clk,
   input  logic                   reset,
   input  logic                   mem_req_valid,
   input  logic                   mem_req_ready,
   input  vecproc_pkg::mem_req_t  mem_req,
   input  logic                   halted,
   input  int                     exp_count,
   input  logic [31:0]            exp_addr [max_stores],
   input  logic [31:0]            exp_data [max_stores]
);
   import vecproc_pkg::*;

   int   error_count;
   int   store_count;
   logic halt_seen;

   // compare one accepted store with the next expected one.
   task automatic check_store();
      if (store_count >= exp_count) begin
         $display("extra store to address %h with data %h", mem_req.addr, mem_req.wdata);
         error_count++;
      end else begin
         if (mem_req.addr !== exp_addr[store_count][`VP_AW-1:0]) begin
            $display("FAIL store %0d mem_req.addr: got %h, expected %h", store_count,
                     mem_req.addr, exp_addr[store_count][`VP_AW-1:0]);
            error_count++;
         end
         if (mem_req.wdata !== exp_data[store_count]) begin
            $display("FAIL store %0d mem_req.wdata: got %h, expected %h", store_count,
                     mem_req.wdata, exp_data[store_count]);
            error_count++;
         end
      end
      store_count++;
   endtask

   always @(posedge clk) begin
      if (reset) begin
         error_count = 0;
         store_count = 0;
         halt_seen   = 1'b0;
      end else begin
         if (halt_seen && !halted) begin
            $display("halted went low again after it was raised");
            error_count++;
         end
         // the core must be silent on the memory port once halted.
         if (halted && mem_req_valid) begin
            $display("memory request to address %h issued after halt", mem_req.addr);
            error_count++;
         end
         if (halted) begin
            halt_seen = 1'b1;
         end
         if (mem_req_valid && mem_req_ready && mem_req.write) begin
            check_store();
         end
      end
   end

   // end of run checks, returns the number of new errors.
   function automatic int closing_errors();
      int n;
      n = 0;
      if (store_count < exp_count) begin
         $display("missing stores: saw %0d of %0d expected", store_count, exp_count);
         n++;
      end
      if (!halt_seen) begin
         $display("halted never went high");
         n++;
      end
      return n;
   endfunction

endmodule

`default_nettype wire

//--- test/tb_vecproc.sv
`timescale 1ns/1ns
`default_nettype none
`include "vecproc_settings.svh"

module tb_vecproc;
   import vecproc_pkg::*;

   localparam int stim_depth      = 256;
   localparam int max_stores      = 64;
   localparam int cycles_per_word = 200;

   logic        clk;
   logic        reset;
   logic        mem_req_ready;
   logic        mem_rsp_valid;
   mem_rsp_t    mem_rsp;
   logic        mem_req_valid;
   mem_req_t    mem_req;
   logic        halted;

   logic [31:0] stim [stim_depth];
   logic [31:0] mem [1 << `VP_AW];
   logic [31:0] exp_addr [max_stores];
   logic [31:0] exp_data [max_stores];
   int          prog_len;
   int          exp_count;
   logic        loaded;
   logic        timed_out;

   vecproc_top u_dut (
      .clk(clk), .reset(reset), .mem_req_ready(mem_req_ready),
      .mem_rsp_valid(mem_rsp_valid), .mem_rsp(mem_rsp),
      .mem_req_valid(mem_req_valid), .mem_req(mem_req), .halted(halted)
   );

   vecproc_checker #(.max_stores(max_stores)) u_check (
      .clk(clk), .reset(reset), .mem_req_valid(mem_req_valid),
      .mem_req_ready(mem_req_ready), .mem_req(mem_req), .halted(halted),
      .exp_count(exp_count), .exp_addr(exp_addr), .exp_data(exp_data)
   );

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   // program image at address 0 on top of a fill pattern.
   task automatic load_stim();
      int base;
      $readmemh("test/vecproc_stim.txt", stim);
      prog_len = int'(stim[0]);
      for (int i = 0; i < (1 << `VP_AW); i++) begin
         mem[i] = 32'ha5000000 | 32'(i);
      end
      for (int i = 0; i < prog_len; i++) begin
         mem[i] = stim[1 + i];
      end
      base      = prog_len + 1;
      exp_count = int'(stim[base]);
      for (int i = 0; i < exp_count; i++) begin
         exp_addr[i] = stim[base + 1 + 2 * i];
         exp_data[i] = stim[base + 2 + 2 * i];
      end
   endtask

   task automatic finish_run();
      int errors;
      #1;
      errors = u_check.error_count + u_check.closing_errors();
      $display("stores checked %0d of %0d, errors %0d, timeouts %0d",
               u_check.store_count, exp_count, errors, timed_out ? 1 : 0);
      if (errors == 0 && !timed_out) begin
         $display("ALL CHECKS PASSED");
      end else begin
         $display("CHECKS FAILED");
      end
      $finish;
   endtask

   // memory with random ready stalls and a 1 to 3 cycle read delay.
   initial begin : memory_model
      logic              accept;
      logic              rd_pending;
      logic [`VP_AW-1:0] rd_addr;
      int unsigned       rd_wait;
      void'($urandom(31));
      mem_req_ready = 1'b0;
      mem_rsp_valid = 1'b0;
      mem_rsp       = '0;
      rd_pending    = 1'b0;
      rd_addr       = '0;
      rd_wait       = 0;
      load_stim();
      loaded = 1'b1;
      forever begin
         @(posedge clk);
         accept = !reset && mem_req_valid && mem_req_ready;
         if (accept && mem_req.write) begin
            mem[mem_req.addr] = mem_req.wdata;
         end else if (accept) begin
            rd_pending = 1'b1;
            rd_addr    = mem_req.addr;
            rd_wait    = $urandom_range(2, 0);
         end
         #1;
         mem_rsp_valid = 1'b0;
         mem_req_ready = ($urandom_range(3, 0) != 0);
         if (rd_pending) begin
            if (rd_wait == 0) begin
               mem_rsp_valid = 1'b1;
               mem_rsp.rdata = mem[rd_addr];
               rd_pending    = 1'b0;
            end else begin
               rd_wait = rd_wait - 1;
            end
         end
      end
   end

   initial begin : main_flow
      reset = 1'b1;
      repeat (3) @(posedge clk);
      #1;
      reset = 1'b0;
      wait (halted === 1'b1);
      // quiet window to catch requests after halt.
      repeat (20) @(posedge clk);
      finish_run();
   end

   initial begin : watchdog
      timed_out = 1'b0;
      wait (loaded === 1'b1);
      repeat (cycles_per_word * prog_len) @(posedge clk);
      $display("timeout: run did not end within %0d cycles", cycles_per_word * prog_len);
      timed_out = 1'b1;
      finish_run();
   end

endmodule

`default_nettype wire

//--- filelist.f
+incdir+logic
logic/vecproc_pkg.sv
logic/mem_arbiter.sv
logic/fetch_stage.sv
logic/register_file.sv
logic/decode_stage.sv
logic/decode_execute_register.sv
logic/execute_stage.sv
logic/vecproc_top.sv
test/vecproc_checker.sv
test/tb_vecproc.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_vecproc
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
STIM      ?= test/vecproc_stim.txt
VFLAGS    ?= --binary --timing --assert -j 0

SOURCES := $(shell grep -v '^+' $(FILELIST))
HEADERS := $(wildcard logic/*.svh)
SIM     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM): $(FILELIST) $(SOURCES) $(HEADERS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: $(SIM) $(STIM)
	$(SIM) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "CHECKS FAILED" $(LOG); then exit 1; fi
	@grep -q "ALL CHECKS PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- test/vecproc_stim.txt
// word 0 is the program length, then the program words from address 0.
// then the expected store count, then address/data pairs in store order.
00000023
// lui, dependent addi, sign-extended addi, wrapping add, store
48400123 40420045 40800FFF 08C22000 58003100
// wrapping sub, store
11041000 58004101
// shifts by r5, and, or, xor, two stores
41400004 31825000 39C45000 1A0C7000 22505000 2A922000
58006102 5800A103
// load a stored value and use it at once
52C00100 4316000C 5800C104
// two broadcasts, vadd, vmul, vsub, lane extracts, stores
434007FF 785A0000 43800123 789C0000
60C22000 71021000 69441000
83C60005 84080000 844A0007
5800F105 58010106 58011107
// second load, dependent add, store, halt
54800103 0CE52000 58013108
88000000
// expected stores
00000009
00000100 00001274
00000101 0000ED8A
00000102 00002750
00000103 0000F8AB
00000104 00001280
00000105 00000922
00000106 0000F001
00000107 0000F924
00000108 0000F156
